/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    localparam int imem_aw    = $clog2(imem_words);
    localparam int dmem_aw    = $clog2(dmem_words);

    // Major opcodes of the supported subset
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [xlen-1:0] ecall_word = 32'h0000_0073;

    // One instruction word, read as register fields or as immediate fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_regfile,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link
    } wb_sel_e;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              restart,
    input  logic              stall,
    input  logic              flush,
    input  logic              branch_taken,
    input  logic [xlen-1:0]   branch_target,
    input  logic              prog_we,
    input  logic [imem_aw-1:0] prog_addr,
    input  logic [xlen-1:0]   prog_data,
    output logic              if_valid,
    output logic [xlen-1:0]   if_pc,
    output logic [xlen-1:0]   if_instr
);

    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] pc;

    // Program load port, only used while the core is halted
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || restart) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            // Redirect, and the wrong-path word is dropped
            pc       <= branch_target;
            if_valid <= 1'b0;
        end else if (flush || !run) begin
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + xlen'(4);
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_instr <= imem[pc[imem_aw+1:2]];
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            flush,
    input  logic            if_valid,
    input  logic [xlen-1:0] if_pc,
    input  logic [xlen-1:0] if_instr,
    input  logic            wb_we,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    output logic [4:0]      id_rs1,
    output logic [4:0]      id_rs2,
    output logic            id_uses_rs2,
    output logic            ex_valid,
    output logic [xlen-1:0] ex_pc,
    output logic [4:0]      ex_rs1,
    output logic [4:0]      ex_rs2,
    output logic [xlen-1:0] ex_a,
    output logic [xlen-1:0] ex_b,
    output logic [xlen-1:0] ex_imm,
    output logic [4:0]      ex_rd,
    output alu_op_e         ex_alu_op,
    output logic            ex_use_imm,
    output wb_sel_e         ex_wb_sel,
    output logic            ex_reg_we,
    output logic            ex_mem_we,
    output logic            ex_is_load,
    output logic            ex_branch,
    output logic            ex_branch_ne,
    output logic            ex_jal,
    output logic            ex_ecall
);

    instr_u          ins;
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] imm;
    alu_op_e         alu_op;
    wb_sel_e         wb_sel;
    logic uses_rs1, uses_rs2, use_imm, reg_we, mem_we, is_load, branch, jal, ecall;

    assign ins = if_instr;

    // Read with write-through so a value retiring this cycle is seen
    function automatic logic [xlen-1:0] rf_read(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wb_we && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        use_imm  = 1'b0;
        reg_we   = 1'b0;
        mem_we   = 1'b0;
        is_load  = 1'b0;
        branch   = 1'b0;
        jal      = 1'b0;
        ecall    = 1'b0;
        alu_op   = alu_add;
        wb_sel   = wb_alu;
        imm      = {{20{ins.i.imm[11]}}, ins.i.imm};
        case (ins.r.opcode)
            op_op: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                reg_we   = 1'b1;
                case (ins.r.funct3)
                    3'b000:  alu_op = ins.r.funct7[5] ? alu_sub : alu_add;
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: alu_op = alu_add;
                endcase
            end
            op_imm: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                reg_we   = 1'b1;
            end
            op_lui: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
                alu_op  = alu_pass_b;
                imm     = {ins.i.imm, ins.i.rs1, ins.i.funct3, 12'b0};
            end
            op_load: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                is_load  = 1'b1;
                wb_sel   = wb_load;
            end
            op_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                use_imm  = 1'b1;
                mem_we   = 1'b1;
                imm      = {{20{ins.r.funct7[6]}}, ins.r.funct7, ins.r.rd};
            end
            op_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                branch   = 1'b1;
                imm      = {{20{ins.r.funct7[6]}}, ins.r.rd[0], ins.r.funct7[5:0],
                            ins.r.rd[4:1], 1'b0};
            end
            op_jal: begin
                reg_we = 1'b1;
                jal    = 1'b1;
                wb_sel = wb_link;
                imm    = {{12{ins.r.funct7[6]}}, ins.r.rs1, ins.r.funct3, ins.r.rs2[0],
                          ins.r.funct7[5:0], ins.r.rs2[4:1], 1'b0};
            end
            op_system: ecall = (if_instr == ecall_word);
            default: ;
        endcase
    end

    // Unused source fields read as x0 so they never trigger a stall
    assign id_rs1      = (if_valid && uses_rs1) ? ins.r.rs1 : 5'd0;
    assign id_rs2      = ins.r.rs2;
    assign id_uses_rs2 = if_valid & uses_rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_reg_we  <= 1'b0;
            ex_mem_we  <= 1'b0;
            ex_is_load <= 1'b0;
            ex_branch  <= 1'b0;
            ex_jal     <= 1'b0;
            ex_ecall   <= 1'b0;
        end else begin
            ex_valid   <= if_valid & ~stall & ~flush;
            ex_reg_we  <= reg_we & (ins.r.rd != 5'd0);
            ex_mem_we  <= mem_we;
            ex_is_load <= is_load;
            ex_branch  <= branch;
            ex_jal     <= jal;
            ex_ecall   <= ecall;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= if_pc;
        ex_rs1       <= id_rs1;
        ex_rs2       <= id_uses_rs2 ? id_rs2 : 5'd0;
        ex_a         <= rf_read(id_rs1);
        ex_b         <= rf_read(id_rs2);
        ex_imm       <= imm;
        ex_rd        <= ins.r.rd;
        ex_alu_op    <= alu_op;
        ex_use_imm   <= use_imm;
        ex_wb_sel    <= wb_sel;
        ex_branch_ne <= ins.r.funct3[0];
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            halt_flush,
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  logic [xlen-1:0] ex_a,
    input  logic [xlen-1:0] ex_b,
    input  logic [xlen-1:0] ex_imm,
    input  logic [4:0]      ex_rd,
    input  alu_op_e         ex_alu_op,
    input  logic            ex_use_imm,
    input  wb_sel_e         ex_wb_sel,
    input  logic            ex_reg_we,
    input  logic            ex_mem_we,
    input  logic            ex_is_load,
    input  logic            ex_branch,
    input  logic            ex_branch_ne,
    input  logic            ex_jal,
    input  logic            ex_ecall,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [xlen-1:0] wb_data,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target,
    output logic            mem_valid,
    output logic [xlen-1:0] mem_pc,
    output logic [xlen-1:0] mem_alu,
    output logic [xlen-1:0] mem_store_data,
    output logic [4:0]      mem_rd,
    output logic            mem_reg_we,
    output logic            mem_mem_we,
    output logic            mem_is_load,
    output wb_sel_e         mem_wb_sel,
    output logic            mem_ecall
);

    logic [xlen-1:0] op_a, rs2_val, op_b, alu_y;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [xlen-1:0] rf_val);
        case (sel)
            fwd_from_mem: return mem_alu;
            fwd_from_wb:  return wb_data;
            default:      return rf_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_a, ex_a);
    assign rs2_val = fwd_mux(fwd_b, ex_b);
    assign op_b    = ex_use_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            alu_sub:    alu_y = op_a - op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_or:     alu_y = op_a | op_b;
            alu_xor:    alu_y = op_a ^ op_b;
            alu_slt:    alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // BEQ when equal, BNE when not, JAL always
    assign branch_taken  = ex_valid & (ex_jal | (ex_branch & ((op_a == rs2_val) ^ ex_branch_ne)));
    assign branch_target = ex_pc + ex_imm;

    always_ff @(posedge clk) begin
        if (!rst_n || halt_flush) begin
            mem_valid   <= 1'b0;
            mem_reg_we  <= 1'b0;
            mem_mem_we  <= 1'b0;
            mem_is_load <= 1'b0;
            mem_ecall   <= 1'b0;
        end else begin
            mem_valid   <= ex_valid;
            mem_reg_we  <= ex_valid & ex_reg_we;
            mem_mem_we  <= ex_valid & ex_mem_we;
            mem_is_load <= ex_valid & ex_is_load;
            mem_ecall   <= ex_valid & ex_ecall;
        end
    end

    always_ff @(posedge clk) begin
        mem_pc         <= ex_pc;
        mem_alu        <= alu_y;
        mem_store_data <= rs2_val;
        mem_rd         <= ex_rd;
        mem_wb_sel     <= ex_wb_sel;
    end

endmodule

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_valid,
    input  logic [xlen-1:0] mem_pc,
    input  logic [xlen-1:0] mem_alu,
    input  logic [xlen-1:0] mem_store_data,
    input  logic [4:0]      mem_rd,
    input  logic            mem_reg_we,
    input  logic            mem_mem_we,
    input  logic            mem_is_load,
    input  wb_sel_e         mem_wb_sel,
    input  logic            mem_ecall,
    output logic            wb_we,
    output logic [4:0]      wb_rd,
    output logic [xlen-1:0] wb_data,
    output logic            ecall_done,
    output logic            retire_valid,
    output logic [xlen-1:0] retire_pc,
    output logic [4:0]      retire_rd,
    output logic            retire_we,
    output logic [xlen-1:0] retire_data
);

    logic [xlen-1:0]    dmem [dmem_words];
    logic [dmem_aw-1:0] word;
    logic [xlen-1:0]    load_data, result;

    assign word = mem_alu[dmem_aw+1:2];

    always_ff @(posedge clk) begin
        if (mem_mem_we) begin
            dmem[word] <= mem_store_data;
        end
    end

    assign load_data = mem_is_load ? dmem[word] : '0;

    always_comb begin
        case (mem_wb_sel)
            wb_load: result = load_data;
            wb_link: result = mem_pc + xlen'(4);
            default: result = mem_alu;
        endcase
    end

    assign ecall_done = mem_valid & mem_ecall;

    // Trace record, which also acts as the register-file write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= mem_valid;
            retire_we    <= mem_reg_we;
        end
        retire_pc   <= mem_pc;
        retire_rd   <= mem_rd;
        retire_data <= result;
    end

    assign wb_we   = retire_we;
    assign wb_rd   = retire_rd;
    assign wb_data = retire_data;

endmodule

/* pipeline_control.sv */
`timescale 1ns/1ps

module pipeline_control import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic       id_uses_rs2,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_is_load,
    input  logic       ex_valid,
    input  logic       branch_taken,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_we,
    input  logic [4:0] wb_rd,
    input  logic       wb_we,
    input  logic       ecall_done,
    output logic       run,
    output logic       restart,
    output logic       stall,
    output logic       flush,
    output logic       halt_flush,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b,
    output logic       halted
);

    // Nearest producer wins, and x0 is never forwarded
    function automatic fwd_sel_e pick(input logic [4:0] src);
        if (src == 5'd0) begin
            return fwd_regfile;
        end
        if (mem_reg_we && mem_rd == src) begin
            return fwd_from_mem;
        end
        if (wb_we && wb_rd == src) begin
            return fwd_from_wb;
        end
        return fwd_regfile;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted <= 1'b1;
        end else if (restart) begin
            halted <= 1'b0;
        end else if (ecall_done) begin
            halted <= 1'b1;
        end
    end

    assign run     = ~halted;
    assign restart = start & halted;

    // Load result is only ready once the load reaches the memory stage
    assign stall = ex_valid & ex_is_load & (ex_rd != 5'd0) &
                   ((ex_rd == id_rs1) | (id_uses_rs2 & (ex_rd == id_rs2)));

    // Everything behind a retiring ECALL is squashed
    assign halt_flush = halted | ecall_done;
    assign flush      = branch_taken | halt_flush;

    assign fwd_a = pick(ex_rs1);
    assign fwd_b = pick(ex_rs2);

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               prog_we,
    input  logic [imem_aw-1:0] prog_addr,
    input  logic [xlen-1:0]    prog_data,
    output logic               halted,
    output logic               retire_valid,
    output logic [xlen-1:0]    retire_pc,
    output logic [4:0]         retire_rd,
    output logic               retire_we,
    output logic [xlen-1:0]    retire_data
);

    // Control
    logic     run, restart, stall, flush, halt_flush, ecall_done;
    fwd_sel_e fwd_a, fwd_b;

    // Fetch to decode
    logic            if_valid;
    logic [xlen-1:0] if_pc, if_instr;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;

    // Decode to execute
    logic [4:0]      id_rs1, id_rs2;
    logic            id_uses_rs2;
    logic            ex_valid;
    logic [xlen-1:0] ex_pc, ex_a, ex_b, ex_imm;
    logic [4:0]      ex_rs1, ex_rs2, ex_rd;
    alu_op_e         ex_alu_op;
    wb_sel_e         ex_wb_sel;
    logic ex_use_imm, ex_reg_we, ex_mem_we, ex_is_load;
    logic ex_branch, ex_branch_ne, ex_jal, ex_ecall;

    // Execute to memory
    logic            mem_valid;
    logic [xlen-1:0] mem_pc, mem_alu, mem_store_data;
    logic [4:0]      mem_rd;
    wb_sel_e         mem_wb_sel;
    logic mem_reg_we, mem_mem_we, mem_is_load, mem_ecall;

    // Register-file write
    logic            wb_we;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;

    fetch_stage fetch_i (.*);

    decode_stage decode_i (.*);

    execute_stage execute_i (.*);

    memory_stage memory_i (.*);

    pipeline_control control_i (.*);

endmodule

/* cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       prog_we,
    input logic       halted,
    input logic       retire_valid,
    input logic       retire_we,
    input logic [4:0] retire_rd
);

    // Load port only while the core is stopped
    assert property (@(posedge clk) disable iff (!rst_n) prog_we |-> halted)
        else $error("program write while the core was running");

    // Only the ECALL record overlaps the first halted cycle
    assert property (@(posedge clk) disable iff (!rst_n) retire_valid && halted |-> $rose(halted))
        else $error("retire seen while the core was halted");

    assert property (@(posedge clk) disable iff (!rst_n) retire_we |-> retire_rd != 5'd0)
        else $error("retire shows a write to x0");

endmodule

bind cpu_top cpu_assertions cpu_assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .prog_we      (prog_we),
    .halted       (halted),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd)
);

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int num_tests   = 10;
    localparam int max_len     = 40;
    localparam int clk_period  = 4;
    // Loading time and restart overhead on top of the run time
    localparam int watchdog_ns = num_tests * 3 * max_len * clk_period
                               + num_tests * (max_len + 20) * clk_period + 100;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic               prog_we;
    logic [imem_aw-1:0] prog_addr;
    logic [xlen-1:0]    prog_data;
    logic               halted;
    logic               retire_valid;
    logic [xlen-1:0]    retire_pc;
    logic [4:0]         retire_rd;
    logic               retire_we;
    logic [xlen-1:0]    retire_data;

    // Generator state
    logic [31:0]     lfsr;
    logic [xlen-1:0] prog [imem_words];
    int              prog_len;
    int              pos;
    logic [4:0]      last_rd;
    logic            defined [32];
    logic            mem_def [dmem_words];

    // ISA model state and expected trace
    logic [xlen-1:0] mreg [32];
    logic [xlen-1:0] mdmem [dmem_words];
    logic [xlen-1:0] exp_pc [imem_words];
    logic [4:0]      exp_rd [imem_words];
    logic            exp_we [imem_words];
    logic [xlen-1:0] exp_data [imem_words];
    int              exp_count;
    int              ret_idx;
    int              retired;
    int              errors;

    cpu_top cpu_top_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < count; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic coin();
        return lfsr_bits(1) == 32'd1;
    endfunction

    // Only registers already written count as sources
    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        r = 5'(lfsr_bits(5));
        return defined[r] ? r : 5'd0;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // Restricted ops sit in a branch shadow and only write registers already defined
    task automatic emit_alu(input logic restricted);
        logic [2:0] op;
        logic [4:0] rd, rs1, rs2;
        op  = 3'(lfsr_bits(3));
        rd  = 5'(lfsr_bits(5));
        if (restricted && !defined[rd]) begin
            rd = 5'd0;
        end
        rs1 = coin() ? last_rd : pick_src();
        rs2 = pick_src();
        case (op)
            3'd0:    prog[pos] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
            3'd1:    prog[pos] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
            3'd2:    prog[pos] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3'd3:    prog[pos] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
            3'd4:    prog[pos] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
            3'd5:    prog[pos] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
            3'd6:    prog[pos] = enc_i(12'(lfsr_bits(12)), rs1, 3'b000, rd, op_imm);
            default: prog[pos] = {20'(lfsr_bits(20)), rd, op_lui};
        endcase
        defined[rd] = 1'b1;
        last_rd     = rd;
        pos         = pos + 1;
    endtask

    task automatic gen_program();
        int          forced;
        int          room;
        int          skip;
        logic [2:0]  kind;
        logic [4:0]  rd, rs1, rs2, base;
        logic [5:0]  word;
        logic [11:0] off, eff;
        prog_len = 12 + int'(lfsr_bits(5) % 29);
        pos      = 0;
        forced   = 0;
        while (pos < prog_len - 1) begin
            // Words left between this slot and the ECALL
            room = prog_len - 2 - pos;
            if (forced > 0) begin
                emit_alu(1'b1);
                forced = forced - 1;
            end else begin
                kind = 3'(lfsr_bits(3));
                if (kind == 3'd4 || kind == 3'd5) begin
                    skip = int'(lfsr_bits(2)) + 1;
                    if (skip > room) begin
                        skip = room;
                    end
                    forced = skip;
                    if (kind == 3'd4) begin
                        rs1       = pick_src();
                        rs2       = coin() ? rs1 : pick_src();
                        prog[pos] = enc_b(13'(4 * (skip + 1)), rs2, rs1, {2'b00, coin()});
                    end else begin
                        rd          = 5'(lfsr_bits(5));
                        prog[pos]   = enc_j(21'(4 * (skip + 1)), rd);
                        defined[rd] = 1'b1;
                        last_rd     = rd;
                    end
                    pos = pos + 1;
                end else if (kind >= 3'd6 && room >= 1) begin
                    // Base register, then one store or load through it
                    base = 5'(lfsr_bits(4)) + 5'd1;
                    word = 6'(lfsr_bits(6));
                    off  = 12'(lfsr_bits(2) * 4);
                    eff  = {4'd0, word, 2'd0} + off;
                    prog[pos]     = enc_i({4'd0, word, 2'd0}, 5'd0, 3'b000, base, op_imm);
                    defined[base] = 1'b1;
                    if (mem_def[eff[7:2]] && coin()) begin
                        rd            = 5'(lfsr_bits(5));
                        prog[pos + 1] = enc_i(off, base, 3'b010, rd, op_load);
                        defined[rd]   = 1'b1;
                        last_rd       = rd;
                    end else begin
                        prog[pos + 1]     = enc_s(off, pick_src(), base);
                        mem_def[eff[7:2]] = 1'b1;
                    end
                    pos = pos + 2;
                end else begin
                    emit_alu(1'b0);
                end
            end
        end
        prog[prog_len - 1] = ecall_word;
    endtask

    // Reference execution straight from the ISA encoding
    task automatic run_model();
        logic [31:0] w, a, b, res, pc, npc, addr;
        logic [4:0]  rd;
        logic        we, done;
        exp_count = 0;
        pc        = '0;
        done      = 1'b0;
        while (!done && exp_count < imem_words) begin
            w   = prog[pc[7:2]];
            rd  = w[11:7];
            a   = mreg[w[19:15]];
            b   = mreg[w[24:20]];
            we  = 1'b1;
            res = '0;
            npc = pc + 32'd4;
            case (w[6:0])
                op_op: begin
                    case (w[14:12])
                        3'b000:  res = w[30] ? a - b : a + b;
                        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                op_imm: res = a + {{20{w[31]}}, w[31:20]};
                op_lui: res = {w[31:12], 12'b0};
                op_load: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = mdmem[addr[7:2]];
                end
                op_store: begin
                    we   = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    mdmem[addr[7:2]] = b;
                end
                op_branch: begin
                    we = 1'b0;
                    if ((a == b) != w[12]) begin
                        npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    res = pc + 32'd4;
                    npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: begin
                    we   = 1'b0;
                    done = 1'b1;
                end
            endcase
            we = we && (rd != 5'd0);
            if (we) begin
                mreg[rd] = res;
            end
            exp_pc[exp_count]   = pc;
            exp_rd[exp_count]   = rd;
            exp_we[exp_count]   = we;
            exp_data[exp_count] = res;
            exp_count           = exp_count + 1;
            pc                  = npc;
        end
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got, exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] got, exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < prog_len; k++) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = imem_aw'(k);
            prog_data = prog[k];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic run_program();
        ret_idx = 0;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        if (ret_idx != exp_count) begin
            errors = errors + 1;
            $display("Trace ended with %0d records where %0d were expected", ret_idx, exp_count);
        end
    endtask

    // Trace monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            if (ret_idx >= exp_count) begin
                errors = errors + 1;
                $display("Instruction at pc %h retired after the program had ended", retire_pc);
            end else begin
                check_word("retire_pc", retire_pc, exp_pc[ret_idx]);
                check_flag("retire_we", retire_we, exp_we[ret_idx]);
                if (exp_we[ret_idx]) begin
                    check_reg("retire_rd", retire_rd, exp_rd[ret_idx]);
                    check_word("retire_data", retire_data, exp_data[ret_idx]);
                end
                // Halt coincides with the ECALL record
                check_flag("halted", halted, ret_idx == exp_count - 1);
                ret_idx = ret_idx + 1;
            end
            retired = retired + 1;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        lfsr      = 32'd68862;
        last_rd   = 5'd0;
        errors    = 0;
        retired   = 0;
        exp_count = 0;
        ret_idx   = 0;
        for (int k = 0; k < 32; k++) begin
            mreg[k]    = '0;
            defined[k] = (k == 0);
        end
        for (int k = 0; k < dmem_words; k++) begin
            mdmem[k]   = '0;
            mem_def[k] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag("halted", halted, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        for (int t = 0; t < num_tests; t++) begin
            gen_program();
            run_model();
            load_program();
            run_program();
        end
        $display("Tests %0d, retired %0d, errors %0d", num_tests, retired, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Run timed out after %0d ns without reaching the end", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* src.f */
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
pipeline_control.sv
cpu_top.sv
cpu_assertions.sv
cpu_tb.sv

/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: run clean

obj_dir/Vcpu_tb: src.f $(SRCS)
	verilator --binary --timing --assert --top-module cpu_tb -f src.f -o Vcpu_tb

run: obj_dir/Vcpu_tb
	obj_dir/Vcpu_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
